/* list.f */
+incdir+include
logic/mem_pkg.sv
logic/lane_lsu.sv
logic/dtim_banked.sv
logic/memory_stage.sv
logic/mem_subsystem.sv
tb/mem_checker.sv
tb/tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

export_include_dirs:
  - include

sources:
  - files:
      - logic/mem_pkg.sv
      - logic/lane_lsu.sv
      - logic/dtim_banked.sv
      - logic/memory_stage.sv
      - logic/mem_subsystem.sv
  - target: test
    files:
      - tb/mem_checker.sv
      - tb/tb_mem_subsystem.sv

/* tb/tb_mem_subsystem.sv */
`default_nettype none

`include "mem_defs.svh"

module tb_mem_subsystem;
  import mem_pkg::*;

  localparam int AW = `ADDR_WIDTH;
  localparam int FILL_BUNDLES = `MEM_WORDS / 2;
  localparam int RANDOM_BUNDLES = 300;
  localparam int TOTAL_BUNDLES = 2 * FILL_BUNDLES + 3 * RANDOM_BUNDLES;
  localparam int CYCLE_LIMIT = 20 * TOTAL_BUNDLES + 200;

  logic clock;
  logic reset;
  logic flush;
  logic in_valid;
  logic in_ready;
  bundle_in_type in_bundle;
  logic out_valid;
  logic out_ready;
  bundle_out_type out_bundle;

  bundle_out_type expected_q[$];
  string expected_name[$]; // test name of each expected bundle
  string test_name;
  logic [`XLEN-1:0] model_mem [`MEM_WORDS];
  logic [31:0] lfsr;
  logic took; // a bundle was accepted on the last rising edge
  logic lane1_owed;
  logic [AW-3:0] lane1_word;
  logic [`XLEN-1:0] lane1_before;
  int cycles;
  int checks;
  int mismatches;
  int faults;

  mem_subsystem i_mem_subsystem (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_bundle  (in_bundle),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_bundle (out_bundle)
  );

  mem_checker i_mem_checker (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_bundle  (in_bundle),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_bundle (out_bundle),
    .checks     (checks),
    .mismatches (mismatches),
    .faults     (faults)
  );

  always #2 clock = ~clock;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random numbers and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0); // galois step
    end
    return v;
  endfunction

  function automatic logic [`XLEN-1:0] fill_value(input int w);
    return 32'(32'h9e3779b9 * (w + 1)) ^ 32'(w << 20);
  endfunction

  function automatic lane_res_type ref_lane(input lane_req_type r);
    lane_res_type res;
    logic [`XLEN-1:0] v;
    int w;
    int sh;
    w = r.addr[AW-1:2];
    sh = 8 * r.addr[1:0];
    if (r.op.store == 1) begin
      case (r.op.size)
        `SIZE_BYTE: model_mem[w][sh +: 8] = r.sdata[7:0];
        `SIZE_HALF: model_mem[w][sh +: 16] = r.sdata[15:0];
        default: model_mem[w] = r.sdata;
      endcase
    end
    v = model_mem[w] >> sh;
    case (r.op.size)
      `SIZE_BYTE: v = r.op.unsgn ? {24'b0, v[7:0]} : {{24{v[7]}}, v[7:0]};
      `SIZE_HALF: v = r.op.unsgn ? {16'b0, v[15:0]} : {{16{v[15]}}, v[15:0]};
      default: v = model_mem[w];
    endcase
    res.wren = r.op.load;
    res.waddr = r.waddr;
    res.wdata = r.op.load ? v : '0; // writeback ignores data of a store
    return res;
  endfunction

  // lane 0 is older, so it reaches the model first
  function automatic bundle_out_type ref_bundle(input bundle_in_type b);
    bundle_out_type e;
    e.res0 = ref_lane(b.lane0);
    lane1_before = model_mem[b.lane1.addr[AW-1:2]]; // restored if a flush cancels lane 1
    e.res1 = ref_lane(b.lane1);
    return e;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic lane_req_type random_lane();
    lane_req_type r;
    r.op.load = 1'(rand_bits(1));
    r.op.store = ~r.op.load;
    r.op.size = 2'(rand_bits(2));
    if (r.op.size == 2'b11) begin
      r.op.size = `SIZE_WORD;
    end
    r.op.unsgn = 1'(rand_bits(1));
    r.addr = AW'(rand_bits(AW));
    if (r.op.size == `SIZE_HALF) begin
      r.addr[0] = 1'b0;
    end else if (r.op.size == `SIZE_WORD) begin
      r.addr[1:0] = 2'b00;
    end
    r.sdata = rand_bits(32);
    r.waddr = 5'(rand_bits(5));
    return r;
  endfunction

  function automatic bundle_in_type make_bundle(input int mode, input int n);
    bundle_in_type b;
    logic [1:0] pick;
    b.lane0 = random_lane();
    b.lane1 = random_lane();
    if (mode == 0 || mode == 4) begin
      b.lane0.op = {mode == 4, mode == 0, `SIZE_WORD, 1'b0}; // word stores or word loads
      b.lane1.op = b.lane0.op;
      b.lane0.addr = AW'(8 * n); // words 2n and 2n+1 sit in different banks
      b.lane1.addr = AW'(8 * n + 4);
      b.lane0.sdata = fill_value(2 * n);
      b.lane1.sdata = fill_value(2 * n + 1);
    end else begin
      pick = 2'(rand_bits(2));
      if (pick == 0) begin
        b.lane0.op.load = 1'b0; // lane 1 reads back the word lane 0 writes
        b.lane0.op.store = 1'b1;
        b.lane1.op.load = 1'b1;
        b.lane1.op.store = 1'b0;
        b.lane1.addr[AW-1:2] = b.lane0.addr[AW-1:2];
      end else if (pick == 1) begin
        b.lane0.op.load = 1'b1;
        b.lane0.op.store = 1'b0;
        b.lane1.op.load = 1'b1;
        b.lane1.op.store = 1'b0;
        b.lane1.addr[2] = ~b.lane0.addr[2];
      end
    end
    return b;
  endfunction

  task automatic run_phase(input string name, input int count, input int mode);
    int sent;
    sent = 0;
    test_name = name;
    while (sent < count || in_valid == 1) begin
      @(negedge clock);
      if (in_valid == 1 && took == 1) begin
        in_valid = 0;
      end
      out_ready = (mode == 2 || mode == 3) ? (rand_bits(2) != 0) : 1'b1;
      flush = (mode == 3) ? (rand_bits(4) == 0) : 1'b0;
      if (in_valid == 0 && sent < count) begin
        in_bundle = make_bundle(mode, sent);
        in_valid = 1;
        sent++;
      end
    end
  endtask

  task automatic print_counts(input int timeouts);
    $display("checks %0d mismatches %0d other errors %0d timeouts %0d",
             checks, mismatches, faults, timeouts);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // acceptance tracking and run control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clock) begin
    if (reset == 1) begin
      if (lane1_owed == 1) begin
        if (flush == 1) begin
          model_mem[lane1_word] = lane1_before; // the deferred access never happens
          lane1_owed = 0;
        end else if (out_valid == 0 || out_ready == 1) begin
          lane1_owed = 0;
        end
      end
      took = in_valid & in_ready;
      if (took == 1) begin
        expected_q.push_back(ref_bundle(in_bundle));
        expected_name.push_back(test_name);
        lane1_word = in_bundle.lane1.addr[AW-1:2];
        lane1_owed = (in_bundle.lane0.addr[2] == in_bundle.lane1.addr[2]); // same bank
      end
    end
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with %0d bundles still expected at the output",
               cycles, expected_q.size());
      print_counts(1);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    clock = 0;
    reset = 0;
    flush = 0;
    in_valid = 0;
    out_ready = 1;
    in_bundle = '0;
    lfsr = 32'haf07;
    took = 0;
    lane1_owed = 0;
    cycles = 0;
    test_name = "reset";
    repeat (10) @(negedge clock);
    reset = 1;
    run_phase("fill", FILL_BUNDLES, 0);
    run_phase("store_load", RANDOM_BUNDLES, 1);
    run_phase("backpressure", RANDOM_BUNDLES, 2);
    run_phase("flush", RANDOM_BUNDLES, 3);
    run_phase("readback", FILL_BUNDLES, 4);
    while (expected_q.size() != 0) begin
      @(negedge clock);
    end
    repeat (8) @(negedge clock); // room for a stray extra transfer to show up
    print_counts(0);
    if (mismatches + faults == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/mem_checker.sv */
`default_nettype none

module mem_checker (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    in_valid,
  input  logic                    in_ready,
  input  mem_pkg::bundle_in_type  in_bundle,
  input  logic                    out_valid,
  input  logic                    out_ready,
  input  mem_pkg::bundle_out_type out_bundle,
  output int                      checks,
  output int                      mismatches,
  output int                      faults
);
  import mem_pkg::*;

  bundle_out_type held; // output seen while writeback stalled it
  bundle_out_type exp;
  logic held_check;
  logic busy; // an accepted bundle has not reached the output register yet
  logic lane1_wait; // lane 1 of that bundle still waits for its bank
  logic exp_out_valid;
  logic exp_in_ready;
  logic out_free;
  string name;

  // data only counts when the lane writes a register
  task automatic compare_lane(input string test, input string lane,
                              input lane_res_type e, input lane_res_type a);
    logic bad;
    bad = (a.wren !== e.wren) || (a.waddr !== e.waddr);
    if (e.wren == 1 && a.wdata !== e.wdata) begin
      bad = 1;
    end
    checks = checks + 1;
    if (bad == 1) begin
      mismatches = mismatches + 1;
      $display(
        "mismatch %s %s expected wren %0b waddr %0d wdata %h actual wren %0b waddr %0d wdata %h",
        test, lane, e.wren, e.waddr, e.wdata, a.wren, a.waddr, a.wdata);
    end
  endtask

  task automatic verify_control(input string signal, input logic e, input logic a);
    checks = checks + 1;
    if (a !== e) begin
      mismatches = mismatches + 1;
      $display("mismatch %s %s expected %0b actual %0b",
               tb_mem_subsystem.test_name, signal, e, a);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output side watcher
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clock) begin
    if (reset == 0) begin
      checks = 0;
      mismatches = 0;
      faults = 0;
      held_check = 0;
      busy = 0;
      lane1_wait = 0;
      exp_out_valid = 0;
    end else begin
      if (held_check == 1 && (out_valid !== 1'b1 || out_bundle !== held)) begin
        faults = faults + 1;
        $display("output bundle was dropped or changed while writeback held it back");
      end
      held_check = out_valid & ~out_ready & ~flush;
      held = out_bundle;

      // handshake timing of the stage
      out_free = ~exp_out_valid | out_ready;
      verify_control("out_valid", exp_out_valid, out_valid);
      if (flush == 0) begin
        exp_in_ready = out_free & ~lane1_wait;
        verify_control("in_ready", exp_in_ready, in_ready);
      end

      if (out_valid == 1 && out_ready == 1) begin
        if (tb_mem_subsystem.expected_q.size() == 0) begin
          faults = faults + 1;
          $display("output transfer arrived while no bundle was expected");
        end else begin
          exp = tb_mem_subsystem.expected_q.pop_front();
          name = tb_mem_subsystem.expected_name.pop_front();
          compare_lane(name, "lane0", exp.res0, out_bundle.res0);
          compare_lane(name, "lane1", exp.res1, out_bundle.res1);
        end
      end

      // a flush empties the stage, so nothing accepted so far will come out
      if (flush == 1) begin
        tb_mem_subsystem.expected_q.delete();
        tb_mem_subsystem.expected_name.delete();
        exp_out_valid = 0;
        busy = 0;
        lane1_wait = 0;
      end else begin
        if (busy == 1 && lane1_wait == 0 && out_free == 1) begin
          exp_out_valid = 1;
          busy = 0;
        end else if (out_ready == 1) begin
          exp_out_valid = 0;
        end
        if (lane1_wait == 1 && out_free == 1) begin
          lane1_wait = 0; // lane 1 gets its bank on this edge
        end
        if (in_valid == 1 && in_ready == 1) begin
          busy = 1;
          lane1_wait = (in_bundle.lane0.op.load | in_bundle.lane0.op.store)
                     & (in_bundle.lane1.op.load | in_bundle.lane1.op.store)
                     & (in_bundle.lane0.addr[2] == in_bundle.lane1.addr[2]);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/mem_subsystem.sv */
`default_nettype none

module mem_subsystem (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  mem_pkg::bundle_in_type  in_bundle,
  output logic                    out_valid,
  input  logic                    out_ready,
  output mem_pkg::bundle_out_type out_bundle
);
  import mem_pkg::*;

  dtim_req_type dreq_lane0;
  dtim_req_type dreq_lane1;
  dtim_req_type dtim_req0;
  dtim_req_type dtim_req1;
  dtim_rsp_type dtim_rsp0;
  dtim_rsp_type dtim_rsp1;
  lane_res_type res0;
  lane_res_type res1;
  mem_op_type hold_op0;
  mem_op_type hold_op1;
  logic [1:0] hold_addr0;
  logic [1:0] hold_addr1;
  logic [4:0] hold_waddr0;
  logic [4:0] hold_waddr1;

  lane_lsu i_lane_lsu0 (
    .req        (in_bundle.lane0),
    .hold_op    (hold_op0),
    .hold_addr  (hold_addr0),
    .hold_waddr (hold_waddr0),
    .dreq       (dreq_lane0),
    .rdata      (dtim_rsp0.rdata),
    .res        (res0)
  );

  lane_lsu i_lane_lsu1 (
    .req        (in_bundle.lane1),
    .hold_op    (hold_op1),
    .hold_addr  (hold_addr1),
    .hold_waddr (hold_waddr1),
    .dreq       (dreq_lane1),
    .rdata      (dtim_rsp1.rdata),
    .res        (res1)
  );

  dtim_banked i_dtim_banked (
    .clock (clock),
    .reset (reset),
    .req0  (dtim_req0),
    .req1  (dtim_req1),
    .rsp0  (dtim_rsp0),
    .rsp1  (dtim_rsp1)
  );

  memory_stage i_memory_stage (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_bundle   (in_bundle),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_bundle  (out_bundle),
    .dreq_lane0  (dreq_lane0),
    .dreq_lane1  (dreq_lane1),
    .dtim_req0   (dtim_req0),
    .dtim_req1   (dtim_req1),
    .dtim_rsp0   (dtim_rsp0),
    .dtim_rsp1   (dtim_rsp1),
    .res0        (res0),
    .res1        (res1),
    .hold_op0    (hold_op0),
    .hold_op1    (hold_op1),
    .hold_addr0  (hold_addr0),
    .hold_addr1  (hold_addr1),
    .hold_waddr0 (hold_waddr0),
    .hold_waddr1 (hold_waddr1)
  );

endmodule

`default_nettype wire

/* logic/memory_stage.sv */
`default_nettype none

module memory_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  mem_pkg::bundle_in_type  in_bundle,
  output logic                    out_valid,
  input  logic                    out_ready,
  output mem_pkg::bundle_out_type out_bundle,
  input  mem_pkg::dtim_req_type   dreq_lane0,
  input  mem_pkg::dtim_req_type   dreq_lane1,
  output mem_pkg::dtim_req_type   dtim_req0,
  output mem_pkg::dtim_req_type   dtim_req1,
  input  mem_pkg::dtim_rsp_type   dtim_rsp0,
  input  mem_pkg::dtim_rsp_type   dtim_rsp1,
  input  mem_pkg::lane_res_type   res0,
  input  mem_pkg::lane_res_type   res1,
  output mem_pkg::mem_op_type     hold_op0,
  output mem_pkg::mem_op_type     hold_op1,
  output logic [1:0]              hold_addr0,
  output logic [1:0]              hold_addr1,
  output logic [4:0]              hold_waddr0,
  output logic [4:0]              hold_waddr1
);
  import mem_pkg::*;

  typedef struct packed {
    logic acc_valid; // accepted bundle is waiting for its load data
    logic done0; // lane has finished its access on an earlier edge
    logic done1;
    logic out_valid;
  } ctrl_reg_type;

  typedef struct packed {
    mem_op_type op0;
    mem_op_type op1;
    logic [1:0] addr0;
    logic [1:0] addr1;
    logic [4:0] waddr0;
    logic [4:0] waddr1;
    dtim_req_type replay1; // lane 1 request kept for a bank conflict
    lane_res_type res0; // results caught while the port data was live
    lane_res_type res1;
    bundle_out_type out;
  } data_reg_type;

  ctrl_reg_type c, cin;
  data_reg_type d, din;

  logic out_free;
  logic in_fire;
  logic mem0;
  logic mem1;
  logic done0;
  logic done1;
  logic complete;
  logic replay_fire;

  always_comb begin
    cin = c;
    din = d;

    out_free = ~c.out_valid | out_ready;
    mem0 = d.op0.load | d.op0.store;
    mem1 = d.op1.load | d.op1.store;
    done0 = ~mem0 | c.done0 | dtim_rsp0.ready;
    done1 = ~mem1 | c.done1 | dtim_rsp1.ready;

    complete = c.acc_valid & done0 & done1 & out_free;
    replay_fire = c.acc_valid & ~done1 & out_free & ~flush; // done1 low implies a conflict

    in_ready = out_free & ~flush & (~c.acc_valid | (done0 & done1));
    in_fire = in_valid & in_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory requests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dtim_req0 = dreq_lane0;
    dtim_req0.valid = dreq_lane0.valid & in_fire;
    dtim_req1 = replay_fire ? d.replay1 : dreq_lane1;
    dtim_req1.valid = replay_fire | (dreq_lane1.valid & in_fire);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // results
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    if (dtim_rsp0.ready == 1) begin
      din.res0 = res0;
    end
    if (dtim_rsp1.ready == 1) begin
      din.res1 = res1;
    end

    cin.done0 = done0;
    cin.done1 = done1;

    if (complete == 1) begin
      din.out.res0 = dtim_rsp0.ready ? res0 : d.res0;
      din.out.res1 = dtim_rsp1.ready ? res1 : d.res1;
      cin.out_valid = 1;
      cin.acc_valid = 0;
    end else if (out_ready == 1) begin
      cin.out_valid = 0;
    end

    if (in_fire == 1) begin
      cin.acc_valid = 1;
      cin.done0 = 0;
      cin.done1 = 0;
      din.op0 = in_bundle.lane0.op;
      din.op1 = in_bundle.lane1.op;
      din.addr0 = in_bundle.lane0.addr[1:0];
      din.addr1 = in_bundle.lane1.addr[1:0];
      din.waddr0 = in_bundle.lane0.waddr;
      din.waddr1 = in_bundle.lane1.waddr;
      din.replay1 = dreq_lane1;
    end

    // trap or return, whatever sits in the stage is gone
    if (flush == 1) begin
      cin.acc_valid = 0;
      cin.out_valid = 0;
    end

    out_valid = c.out_valid;
    out_bundle = d.out;
    hold_op0 = d.op0;
    hold_op1 = d.op1;
    hold_addr0 = d.addr0;
    hold_addr1 = d.addr1;
    hold_waddr0 = d.waddr0;
    hold_waddr1 = d.waddr1;
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      c <= '0;
    end else begin
      c <= cin;
    end
  end

  always_ff @(posedge clock) begin
    d <= din;
  end

endmodule

`default_nettype wire

/* logic/dtim_banked.sv */
`default_nettype none

`include "mem_defs.svh"

module dtim_banked (
  input  logic                  clock,
  input  logic                  reset,
  input  mem_pkg::dtim_req_type req0,
  input  mem_pkg::dtim_req_type req1,
  output mem_pkg::dtim_rsp_type rsp0,
  output mem_pkg::dtim_rsp_type rsp1
);
  import mem_pkg::*;

  localparam int BANK_WORDS = `MEM_WORDS / 2;
  localparam int IDX_WIDTH = $clog2(BANK_WORDS);

  logic conflict;
  logic [`XLEN-1:0] bank_rdata [2];
  logic bank0_q; // bank that port 0 read last
  logic bank1_q;
  logic ready0_q;
  logic ready1_q;

  // both ports want the same bank, port 0 is the older lane and wins
  assign conflict = req0.valid & req1.valid & (req0.addr[0] == req1.addr[0]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // the two banks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic [`XLEN-1:0] mem [BANK_WORDS];
    logic [`XLEN-1:0] rdata_q;
    logic sel0;
    logic sel1;
    dtim_req_type req;
    logic [IDX_WIDTH-1:0] idx;

    assign sel0 = req0.valid & (req0.addr[0] == 1'(b));
    assign sel1 = req1.valid & (req1.addr[0] == 1'(b)) & ~sel0;
    assign req = sel0 ? req0 : req1;
    assign idx = req.addr[IDX_WIDTH:1];

    always_ff @(posedge clock) begin
      if ((sel0 | sel1) == 1) begin
        for (int i = 0; i < `XLEN/8; i++) begin
          if (req.wstrb[i] == 1) begin
            mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
          end
        end
        rdata_q <= mem[idx]; // old contents on a store, nobody looks at them
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // port responses
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      ready0_q <= 0;
      ready1_q <= 0;
    end else begin
      ready0_q <= req0.valid;
      ready1_q <= req1.valid & ~conflict; // lane 1 has to come again
    end
  end

  always_ff @(posedge clock) begin
    if (req0.valid == 1) begin
      bank0_q <= req0.addr[0];
    end
    if ((req1.valid & ~conflict) == 1) begin
      bank1_q <= req1.addr[0];
    end
  end

  // the bank register can be overwritten later, so rdata is only good while ready
  always_comb begin
    rsp0.rdata = bank_rdata[bank0_q];
    rsp0.ready = ready0_q;
    rsp1.rdata = bank_rdata[bank1_q];
    rsp1.ready = ready1_q;
  end

endmodule

`default_nettype wire

/* logic/lane_lsu.sv */
`default_nettype none

`include "mem_defs.svh"

module lane_lsu (
  input  mem_pkg::lane_req_type req,
  input  mem_pkg::mem_op_type   hold_op,
  input  logic [1:0]            hold_addr,
  input  logic [4:0]            hold_waddr,
  output mem_pkg::dtim_req_type dreq,
  input  logic [`XLEN-1:0]      rdata,
  output mem_pkg::lane_res_type res
);

  logic [`XLEN-1:0] shifted;
  logic [`XLEN-1:0] ldata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    dreq.valid = req.op.load | req.op.store;
    dreq.addr = req.addr[`ADDR_WIDTH-1:2];
    case (req.op.size)
      `SIZE_BYTE: begin
        dreq.wdata = {(`XLEN/8){req.sdata[7:0]}}; // same byte on every lane
        dreq.wstrb = 4'b0001 << req.addr[1:0];
      end
      `SIZE_HALF: begin
        dreq.wdata = {(`XLEN/16){req.sdata[15:0]}};
        dreq.wstrb = req.addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dreq.wdata = req.sdata;
        dreq.wstrb = 4'b1111;
      end
    endcase
    if (req.op.store == 0) begin
      dreq.wstrb = 4'b0000; // a load must leave the word untouched
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // load return side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    shifted = rdata >> {hold_addr, 3'b000}; // addressed byte or half down to bit 0
    case (hold_op.size)
      `SIZE_BYTE: begin
        if (hold_op.unsgn == 1) begin
          ldata = {{(`XLEN-8){1'b0}}, shifted[7:0]};
        end else begin
          ldata = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
        end
      end
      `SIZE_HALF: begin
        if (hold_op.unsgn == 1) begin
          ldata = {{(`XLEN-16){1'b0}}, shifted[15:0]};
        end else begin
          ldata = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
        end
      end
      default: ldata = rdata;
    endcase

    res.wren = hold_op.load; // stores write no register
    res.waddr = hold_waddr;
    res.wdata = ldata;
  end

endmodule

`default_nettype wire

/* logic/mem_pkg.sv */
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // execute to memory
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic load;
    logic store;
    logic [1:0] size; // see the size codes in mem_defs.svh
    logic unsgn; // zero extension for byte and half loads
  } mem_op_type;

  typedef struct packed {
    mem_op_type op;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`XLEN-1:0] sdata;
    logic [4:0] waddr;
  } lane_req_type;

  // lane0 is the older instruction of the pair
  typedef struct packed {
    lane_req_type lane0;
    lane_req_type lane1;
  } bundle_in_type;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory to writeback
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic wren;
    logic [4:0] waddr;
    logic [`XLEN-1:0] wdata;
  } lane_res_type;

  typedef struct packed {
    lane_res_type res0;
    lane_res_type res1;
  } bundle_out_type;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data memory ports
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic valid;
    logic [`ADDR_WIDTH-3:0] addr; // word address, bit 0 picks the bank
    logic [`XLEN-1:0] wdata;
    logic [3:0] wstrb; // all zero for a load
  } dtim_req_type;

  typedef struct packed {
    logic [`XLEN-1:0] rdata;
    logic ready; // the access of this port was performed on the last edge
  } dtim_rsp_type;

endpackage

`default_nettype wire

/* include/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data path and memory geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define XLEN 32
`define ADDR_WIDTH 10 // byte address, 1 KiB space
`define MEM_WORDS 256 // split over two banks by address bit 2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// access size encoding of mem_op_type.size
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SIZE_BYTE 2'b00
`define SIZE_HALF 2'b01
`define SIZE_WORD 2'b10

`endif
